/* sdr_settings.svh */
// size and limit macros for the dense-to-SDR encoder

`ifndef SDR_SETTINGS_SVH
`define SDR_SETTINGS_SVH

// dense input vector width
`define SDR_DENSE_W     32

// parallel scan lanes, SDR_DENSE_W must be a multiple of this
`define SDR_LANES       4

// bits scanned by each lane
`define SDR_SEG_LEN     ((`SDR_DENSE_W) / (`SDR_LANES))

// index width, wide enough for any bit position of the dense vector
`define SDR_IDX_W       ($clog2(`SDR_DENSE_W))

// per-lane queue entries
`define SDR_LANE_DEPTH  4

// most indices one encode may emit before the sparsity error
`define SDR_MAX_ACTIVE  8

`endif

/* sdr_pkg.sv */
// shared state enum and packed bundles of the SDR encoder

`include "sdr_settings.svh"

package sdr_pkg;

    // control FSM states
    typedef enum logic [2:0] {
        IDLE,
        SHIFT_DATA_st,
        SDR_INDEX_st,
        SDR_DONE_st,
        SDR_ERROR_st
    } sdr_state_e;

    // loader to lane, one scan step
    typedef struct packed {
        logic                   step;
        logic                   scan_bit;
        logic [`SDR_IDX_W-1:0]  pos;
    } sdr_lane_feed_t;

    // lane to collector
    typedef struct packed {
        logic                   not_empty;
        logic [`SDR_IDX_W-1:0]  head_idx;
        logic                   overflow;
    } sdr_lane_status_t;

    // emitted index
    typedef struct packed {
        logic                   valid;
        logic [`SDR_IDX_W-1:0]  idx;
    } sdr_index_t;

    typedef struct packed {
        logic                   busy;
        logic                   done;
        logic                   err_sparsity;
        logic                   err_overflow;
    } sdr_status_t;

endpackage

/* sdr_dense_loader.sv */
// dense vector capture and per-lane bit shifter with shared scan counter

`timescale 1ns/100ps

`include "sdr_settings.svh"

module sdr_dense_loader (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic [`SDR_DENSE_W-1:0]                       dense_i,
    input  logic                                          shift_counter_rst,
    input  logic                                          shift_counter_en,
    output sdr_pkg::sdr_lane_feed_t [`SDR_LANES-1:0]      lane_feed_o,
    output logic                                          shift_counter_cnt_dn
);

    localparam int IDX_W   = `SDR_IDX_W;
    localparam int SEG_LEN = `SDR_SEG_LEN;

    logic [SEG_LEN-1:0] seg_q [`SDR_LANES];
    logic [IDX_W-1:0]   pos_q;

    assign shift_counter_cnt_dn = shift_counter_en && (pos_q == IDX_W'(SEG_LEN - 1));

    // segment shift registers, lowest bit scanned first
    always_ff @(posedge clk_i)
    begin
        for (int l = 0; l < `SDR_LANES; l++)
        begin
            if (shift_counter_rst)
            begin
                seg_q[l] <= dense_i[l*SEG_LEN +: SEG_LEN];
            end
            else if (shift_counter_en)
            begin
                seg_q[l] <= seg_q[l] >> 1;
            end
        end
    end

    // position inside the segment
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            pos_q <= '0;
        end
        else if (shift_counter_rst)
        begin
            pos_q <= '0;
        end
        else if (shift_counter_en)
        begin
            pos_q <= shift_counter_cnt_dn ? '0 : pos_q + 1'b1;
        end
    end

    always_comb
    begin
        for (int l = 0; l < `SDR_LANES; l++)
        begin
            lane_feed_o[l].step     = shift_counter_en;
            lane_feed_o[l].scan_bit = seg_q[l][0];
            lane_feed_o[l].pos      = pos_q;
        end
    end

endmodule

/* sdr_lane_fifo.sv */
// scan lane, turns hits into global indices and queues them

`timescale 1ns/100ps

`include "sdr_settings.svh"

module sdr_lane_fifo #(
    parameter int unsigned LANE_ID = 0
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  sdr_pkg::sdr_lane_feed_t   feed_i,
    input  logic                      clr_i,
    input  logic                      pop_i,
    output sdr_pkg::sdr_lane_status_t status_o
);

    localparam int IDX_W = `SDR_IDX_W;
    localparam int DEPTH = `SDR_LANE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [IDX_W-1:0] SEG_BASE = IDX_W'(LANE_ID * `SDR_SEG_LEN);

    logic [IDX_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             ovf_q;
    logic             hit;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign hit  = feed_i.step && feed_i.scan_bit;
    assign full = (count_q == CNT_W'(DEPTH));
    assign push = hit && !full;
    assign pop  = pop_i && (count_q != '0);

    always_ff @(posedge clk_i)
    begin
        if (push)
        begin
            mem_q[wr_ptr_q] <= SEG_BASE + feed_i.pos;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ovf_q    <= 1'b0;
        end
        else if (clr_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ovf_q    <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop)
            begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // hit dropped on a full queue
            if (hit && full)
            begin
                ovf_q <= 1'b1;
            end
        end
    end

    assign status_o.not_empty = (count_q != '0);
    assign status_o.head_idx  = mem_q[rd_ptr_q];
    assign status_o.overflow  = ovf_q;

endmodule

/* sdr_index_collector.sv */
// index collector, drains lanes lowest first and counts emitted indices

`timescale 1ns/100ps

`include "sdr_settings.svh"

module sdr_index_collector (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  sdr_pkg::sdr_lane_status_t [`SDR_LANES-1:0]  lane_status_i,
    input  logic                                        fifo_rready_i,
    input  logic                                        sdr_indexes_counter_rst,
    output logic [`SDR_LANES-1:0]                       lane_pop_o,
    output logic                                        fifo_rvalid_o,
    output logic                                        fifo_full,
    output logic                                        sdr_indexes_counter_cnt_dn,
    output sdr_pkg::sdr_index_t                         index_o
);

    localparam int IDX_W = `SDR_IDX_W;
    localparam int CNT_W = $clog2(`SDR_MAX_ACTIVE + 1);

    logic [CNT_W-1:0] count_q;
    logic             pop_en;
    logic             any_valid;
    logic             any_ovf;
    logic [IDX_W-1:0] head_sel;
    logic             idx_valid_q;
    logic [IDX_W-1:0] idx_q;

    assign sdr_indexes_counter_cnt_dn = (count_q == CNT_W'(`SDR_MAX_ACTIVE));
    assign pop_en                     = fifo_rready_i && !sdr_indexes_counter_cnt_dn;

    // lowest non-empty lane holds the smallest pending index
    always_comb
    begin
        lane_pop_o = '0;
        head_sel   = '0;
        any_valid  = 1'b0;
        any_ovf    = 1'b0;
        for (int l = 0; l < `SDR_LANES; l++)
        begin
            any_ovf = any_ovf | lane_status_i[l].overflow;
            if (!any_valid && lane_status_i[l].not_empty)
            begin
                any_valid     = 1'b1;
                lane_pop_o[l] = pop_en;
                head_sel      = lane_status_i[l].head_idx;
            end
        end
    end

    assign fifo_rvalid_o = any_valid;
    assign fifo_full     = any_ovf;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            count_q     <= '0;
            idx_valid_q <= 1'b0;
        end
        else
        begin
            idx_valid_q <= pop_en && any_valid;
            if (sdr_indexes_counter_rst)
            begin
                count_q <= '0;
            end
            else if (pop_en && any_valid)
            begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (pop_en && any_valid)
        begin
            idx_q <= head_sel;
        end
    end

    assign index_o.valid = idx_valid_q;
    assign index_o.idx   = idx_q;

endmodule

/* sdr_control_fsm.sv */
// control FSM of the SDR encoder
// sequences capture, scan, index drain, done and error

`timescale 1ns/100ps

module sdr_control_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic sdr_start,
    input  logic shift_counter_cnt_dn,
    input  logic fifo_rvalid_o,
    input  logic sdr_indexes_counter_cnt_dn,
    input  logic fifo_full,
    output logic fifo_rready_i,
    output logic shift_counter_rst,
    output logic shift_counter_en,
    output logic sdr_indexes_counter_rst,
    output logic fifo_clr_i,
    output logic convert_done,
    output logic error_fifo_full,
    output logic error_st,
    output logic busy_o
);

    import sdr_pkg::*;

    sdr_state_e state_q;
    sdr_state_e state_d;
    logic       start_accept;
    logic       ovf_q;

    // start is only taken when the FSM is not busy scanning or draining
    assign start_accept = sdr_start &&
                          (state_q == IDLE || state_q == SDR_DONE_st ||
                           state_q == SDR_ERROR_st);

    assign busy_o          = (state_q != IDLE);
    assign error_fifo_full = ovf_q;

    //////////////////////////////////////////////////////////////////////
    // state register and next state
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE, SDR_DONE_st, SDR_ERROR_st:
            begin
                if (sdr_start)
                begin
                    state_d = SHIFT_DATA_st;
                end
            end
            SHIFT_DATA_st:
            begin
                if (shift_counter_cnt_dn)
                begin
                    state_d = SDR_INDEX_st;
                end
            end
            SDR_INDEX_st:
            begin
                // sparsity limit wins over an empty queue
                if (sdr_indexes_counter_cnt_dn)
                begin
                    state_d = SDR_ERROR_st;
                end
                else if (!fifo_rvalid_o)
                begin
                    state_d = SDR_DONE_st;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // sticky overflow, a drop on the last scan step lands in SDR_INDEX_st
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            ovf_q <= 1'b0;
        end
        else if (start_accept)
        begin
            ovf_q <= 1'b0;
        end
        else if (fifo_full && (state_q == SHIFT_DATA_st || state_q == SDR_INDEX_st))
        begin
            ovf_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-state control levels
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        shift_counter_rst       = 1'b0;
        shift_counter_en        = 1'b0;
        fifo_rready_i           = 1'b0;
        sdr_indexes_counter_rst = 1'b0;
        fifo_clr_i              = 1'b0;
        convert_done            = 1'b0;
        error_st                = 1'b0;
        case (state_q)
            SHIFT_DATA_st:
            begin
                shift_counter_en        = 1'b1;
                sdr_indexes_counter_rst = 1'b1;
            end
            SDR_INDEX_st:
            begin
                fifo_rready_i = 1'b1;
                convert_done  = !fifo_rvalid_o && !sdr_indexes_counter_cnt_dn;
                error_st      = sdr_indexes_counter_cnt_dn;
            end
            SDR_DONE_st, SDR_ERROR_st:
            begin
                if (sdr_start)
                begin
                    shift_counter_rst       = 1'b1;
                    sdr_indexes_counter_rst = 1'b1;
                    fifo_clr_i              = 1'b1;
                end
                else
                begin
                    convert_done = (state_q == SDR_DONE_st);
                    error_st     = (state_q == SDR_ERROR_st);
                end
            end
            default:
            begin
                // idle keeps the datapath loading and cleared
                shift_counter_rst       = 1'b1;
                sdr_indexes_counter_rst = 1'b1;
                fifo_clr_i              = 1'b1;
            end
        endcase
    end

endmodule

/* sdr_encoder_top.sv */
// top level of the dense-to-SDR encoder
// loader, scan lanes, collector and control FSM

`timescale 1ns/100ps

`include "sdr_settings.svh"

module sdr_encoder_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     start_i,
    input  logic [`SDR_DENSE_W-1:0]  dense_i,
    output sdr_pkg::sdr_index_t      index_o,
    output sdr_pkg::sdr_status_t     status_o
);

    import sdr_pkg::*;

    sdr_lane_feed_t   [`SDR_LANES-1:0] lane_feed;
    sdr_lane_status_t [`SDR_LANES-1:0] lane_status;
    logic             [`SDR_LANES-1:0] lane_pop;

    // FSM control levels
    logic shift_counter_rst;
    logic shift_counter_en;
    logic shift_counter_cnt_dn;
    logic fifo_clr_i;
    logic fifo_rready_i;
    logic fifo_rvalid_o;
    logic fifo_full;
    logic sdr_indexes_counter_rst;
    logic sdr_indexes_counter_cnt_dn;

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    sdr_dense_loader i_sdr_dense_loader (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .dense_i              (dense_i),
        .shift_counter_rst    (shift_counter_rst),
        .shift_counter_en     (shift_counter_en),
        .lane_feed_o          (lane_feed),
        .shift_counter_cnt_dn (shift_counter_cnt_dn)
    );

    for (genvar l = 0; l < `SDR_LANES; l++)
    begin : g_lane
        sdr_lane_fifo #(
            .LANE_ID (l)
        ) i_sdr_lane_fifo (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .feed_i   (lane_feed[l]),
            .clr_i    (fifo_clr_i),
            .pop_i    (lane_pop[l]),
            .status_o (lane_status[l])
        );
    end

    sdr_index_collector i_sdr_index_collector (
        .clk_i                      (clk_i),
        .rst_ni                     (rst_ni),
        .lane_status_i              (lane_status),
        .fifo_rready_i              (fifo_rready_i),
        .sdr_indexes_counter_rst    (sdr_indexes_counter_rst),
        .lane_pop_o                 (lane_pop),
        .fifo_rvalid_o              (fifo_rvalid_o),
        .fifo_full                  (fifo_full),
        .sdr_indexes_counter_cnt_dn (sdr_indexes_counter_cnt_dn),
        .index_o                    (index_o)
    );

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    sdr_control_fsm i_sdr_control_fsm (
        .clk_i                      (clk_i),
        .rst_ni                     (rst_ni),
        .sdr_start                  (start_i),
        .shift_counter_cnt_dn       (shift_counter_cnt_dn),
        .fifo_rvalid_o              (fifo_rvalid_o),
        .sdr_indexes_counter_cnt_dn (sdr_indexes_counter_cnt_dn),
        .fifo_full                  (fifo_full),
        .fifo_rready_i              (fifo_rready_i),
        .shift_counter_rst          (shift_counter_rst),
        .shift_counter_en           (shift_counter_en),
        .sdr_indexes_counter_rst    (sdr_indexes_counter_rst),
        .fifo_clr_i                 (fifo_clr_i),
        .convert_done               (status_o.done),
        .error_fifo_full            (status_o.err_overflow),
        .error_st                   (status_o.err_sparsity),
        .busy_o                     (status_o.busy)
    );

endmodule

/* tb_sdr_encoder.sv */
// directed testbench of the dense-to-SDR encoder
// clock, reset, reference model, compare task and encode tests

`timescale 1ns/100ps

`include "sdr_settings.svh"

module tb_sdr_encoder;

    import sdr_pkg::*;

    localparam int W       = `SDR_DENSE_W;
    localparam int SEG_LEN = `SDR_SEG_LEN;
    localparam int MAX_ACT = `SDR_MAX_ACTIVE;
    localparam int TIMEOUT = 200;

    logic         clk_i;
    logic         rst_ni;
    logic         start_i;
    logic [W-1:0] dense_i;
    sdr_index_t   index_o;
    sdr_status_t  status_o;

    int   seed;
    int   errors;
    int   checks;
    int   tests;
    int   test_errors;
    int   exp_q[$];
    int   got_q[$];
    logic exp_ovf;
    logic exp_sparse;
    logic timed_out;

    sdr_encoder_top i_sdr_encoder_top (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .start_i  (start_i),
        .dense_i  (dense_i),
        .index_o  (index_o),
        .status_o (status_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected)
        begin
            errors++;
            test_errors++;
            $display("CHECK FAILED at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout after %0d cycles in %s, FSM stuck in %s", TIMEOUT, what,
                 i_sdr_encoder_top.i_sdr_control_fsm.state_q.name());
    endtask

    // ascending hits with at most LANE_DEPTH per segment and the list cut at MAX_ACTIVE
    task automatic model_encode(input logic [W-1:0] vec);
        int hits;
        int kept;
        exp_q.delete();
        exp_ovf = 1'b0;
        kept    = 0;
        for (int s = 0; s < `SDR_LANES; s++)
        begin
            hits = 0;
            for (int b = 0; b < SEG_LEN; b++)
            begin
                if (vec[s*SEG_LEN + b])
                begin
                    if (hits < `SDR_LANE_DEPTH)
                    begin
                        if (kept < MAX_ACT)
                        begin
                            exp_q.push_back(s*SEG_LEN + b);
                        end
                        kept++;
                    end
                    else
                    begin
                        exp_ovf = 1'b1;
                    end
                    hits++;
                end
            end
        end
        exp_sparse = (kept >= MAX_ACT);
    endtask

    function automatic logic [W-1:0] random_sparse_vector();
        logic [W-1:0] vec;
        int           nbits;
        vec   = '0;
        nbits = 1 + int'({$random(seed)} % (MAX_ACT - 1));
        for (int i = 0; i < nbits; i++)
        begin
            vec[{$random(seed)} % W] = 1'b1;
        end
        return vec;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        test_errors = 0;
        check_value(int'(status_o.busy), 0, "busy after reset");
        check_value(int'(status_o.done), 0, "done after reset");
        check_value(int'(status_o.err_sparsity), 0, "err_sparsity after reset");
        check_value(int'(status_o.err_overflow), 0, "err_overflow after reset");
        check_value(int'(index_o.valid), 0, "index valid after reset");
        $display("reset state: %0d errors", test_errors);
        tests++;
    endtask

    // busy_at is the loop cycle of an extra start pulse or -1 for none
    task automatic run_encode(input string name, input logic [W-1:0] vec, input int busy_at);
        int   cycles;
        logic finished;
        if (timed_out)
        begin
            return;
        end
        test_errors = 0;
        got_q.delete();
        model_encode(vec);
        @(posedge clk_i);
        start_i <= 1'b1;
        dense_i <= vec;
        @(posedge clk_i);
        start_i <= 1'b0;
        // vector is taken in the start cycle only
        dense_i <= ~vec;
        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < TIMEOUT)
        begin
            @(posedge clk_i);
            start_i <= (cycles == busy_at);
            @(negedge clk_i);
            if (cycles == 0)
            begin
                check_value(int'(status_o.busy), 1, "busy while scanning");
                check_value(int'(status_o.done), 0, "done cleared by start");
                check_value(int'(status_o.err_sparsity), 0, "err_sparsity cleared by start");
                check_value(int'(status_o.err_overflow), 0, "err_overflow cleared by start");
            end
            if (index_o.valid)
            begin
                got_q.push_back(int'(index_o.idx));
            end
            finished = status_o.done || status_o.err_sparsity;
            cycles++;
        end
        if (!finished)
        begin
            report_timeout(name);
        end
        else
        begin
            check_value(got_q.size(), exp_q.size(), {name, ": index count"});
            for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
            begin
                check_value(got_q[i], exp_q[i], $sformatf("%s: index %0d", name, i));
            end
            // final flags hold and no stray index follows
            for (int c = 0; c < 3; c++)
            begin
                check_value(int'(status_o.done), int'(!exp_sparse), {name, ": done"});
                check_value(int'(status_o.err_sparsity), int'(exp_sparse),
                            {name, ": err_sparsity"});
                check_value(int'(status_o.err_overflow), int'(exp_ovf),
                            {name, ": err_overflow"});
                @(negedge clk_i);
                check_value(int'(index_o.valid), 0, {name, ": index valid after end"});
            end
            $display("%s: %0d indices, %0d errors", name, got_q.size(), test_errors);
            tests++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed      = 32'ha6eb_1c19;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        rst_ni    = 1'b0;
        start_i   = 1'b0;
        dense_i   = '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_reset_state();
        run_encode("zero vector", '0, -1);
        run_encode("sparse fixed", 32'h8001_0420, -1);
        for (int r = 0; r < 4; r++)
        begin
            run_encode($sformatf("sparse random %0d", r), random_sparse_vector(), -1);
        end
        run_encode("sparsity at limit", 32'h0303_0303, -1);
        run_encode("sparsity dense", 32'h0f0f_0f0f, -1);
        run_encode("restart from error", 32'h0000_0012, -1);
        run_encode("lane overflow", 32'h0000_3f00, -1);
        run_encode("overflow and sparsity", 32'hff00_00ff, -1);
        run_encode("restart after overflow", 32'h0480_0100, -1);
        run_encode("restart from done", 32'h0000_0001, -1);
        run_encode("random dense", W'($random(seed)), -1);
        run_encode("start during scan", 32'h2040_8001, 0);
        run_encode("start during drain", 32'h1111_1100, SEG_LEN + 1);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sdr_encoder_top.f */
+incdir+.
sdr_pkg.sv
sdr_dense_loader.sv
sdr_lane_fifo.sv
sdr_index_collector.sv
sdr_control_fsm.sv
sdr_encoder_top.sv
tb_sdr_encoder.sv

/* run_sim.sh */
#!/bin/sh
# compile the SDR encoder testbench with Verilator and run it

set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    -f sdr_encoder_top.f \
    --top-module tb_sdr_encoder \
    --Mdir obj_dir -o tb_sdr_encoder

if ! ./obj_dir/tb_sdr_encoder > sim.log 2>&1; then
    echo "simulator exited with an error"
fi
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
